// File: core_pkg.sv
package core_pkg;

  localparam int WORD_W    = 32;
  localparam int HALF_W    = 16;
  localparam int REG_IDX_W = 3;
  localparam int NUM_REGS  = 8;

  // Instruction field positions
  localparam int IMM_BIT = 31;
  localparam int TYPE_MSB = 30;
  localparam int TYPE_LSB = 29;
  localparam int OP_MSB  = 28;
  localparam int OP_LSB  = 26;
  localparam int RS1_MSB = 21; // Also the destination
  localparam int RS1_LSB = 19;
  localparam int RS2_MSB = 18;
  localparam int RS2_LSB = 16;
  localparam int IMM_MSB = 15;
  localparam int IMM_LSB = 0;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [WORD_W-1:0]    instr_t;
  typedef logic [HALF_W-1:0]    half_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [1:0]           half_en_t; // Bit 0 low half, bit 1 high half

  typedef enum logic [1:0] {
    TYPE_NOP   = 2'd0,
    TYPE_ALU   = 2'd1,
    TYPE_MEM   = 2'd2, // Decoded as no-op
    TYPE_AUDIO = 2'd3  // Decoded as no-op
  } instr_type_e;

  // Unlisted codes are arithmetic ops with a zero result
  typedef enum logic [2:0] {
    OP_ADD  = 3'd1,
    OP_INC  = 3'd3,
    OP_MOVL = 3'd5,
    OP_MOVU = 3'd6,
    OP_MOV  = 3'd7
  } alu_op_e;

  typedef enum logic {
    SRC_ALU  = 1'b0,
    SRC_MOVE = 1'b1
  } wb_src_e;

  typedef struct packed {
    alu_op_e  alu_op;
    word_t    operand_a;
    word_t    operand_b;
    wb_src_e  wb_src;
    reg_idx_t wb_reg;
    half_en_t wb_mask;
  } decode_ex_t;

  typedef struct packed {
    reg_idx_t wb_reg;
    half_en_t wb_mask;
    word_t    wb_data;
  } result_t;

endpackage

// File: instr_decode.sv
module instr_decode (
  input  logic                 clock,
  input  logic                 reset,
  input  core_pkg::instr_t     instr,
  input  logic                 stall,
  output core_pkg::reg_idx_t   rs1_idx,
  output core_pkg::reg_idx_t   rs2_idx,
  output logic                 rs1_used,
  output logic                 rs2_used,
  input  core_pkg::word_t      rs1_value,
  input  core_pkg::word_t      rs2_value,
  output core_pkg::decode_ex_t decode_ex
);

  core_pkg::instr_t      fetch_q;
  logic                  imm_flag;
  core_pkg::instr_type_e instr_type;
  core_pkg::alu_op_e     op;
  core_pkg::half_t       imm;
  logic                  is_alu;
  logic                  is_move;
  core_pkg::decode_ex_t  decode_next;

  // Fetch register holds while stalled
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      fetch_q <= '0; // All zero is a no-op
    end else if (!stall) begin
      fetch_q <= instr;
    end
  end

  // Field split
  assign imm_flag   = fetch_q[core_pkg::IMM_BIT];
  assign instr_type = core_pkg::instr_type_e'(fetch_q[core_pkg::TYPE_MSB:core_pkg::TYPE_LSB]);
  assign op         = core_pkg::alu_op_e'(fetch_q[core_pkg::OP_MSB:core_pkg::OP_LSB]);
  assign rs1_idx    = fetch_q[core_pkg::RS1_MSB:core_pkg::RS1_LSB];
  assign rs2_idx    = fetch_q[core_pkg::RS2_MSB:core_pkg::RS2_LSB];
  assign imm        = fetch_q[core_pkg::IMM_MSB:core_pkg::IMM_LSB];

  assign is_alu  = (instr_type == core_pkg::TYPE_ALU); // MEM and AUDIO fall out as no-ops
  assign is_move = is_alu && (op == core_pkg::OP_MOVL || op == core_pkg::OP_MOVU ||
                              op == core_pkg::OP_MOV);

  // Source usage seen by the hazard unit
  assign rs1_used = is_alu;
  assign rs2_used = is_alu && !imm_flag && (op == core_pkg::OP_ADD || op == core_pkg::OP_MOV);

  always_comb begin
    decode_next.alu_op    = op;
    decode_next.operand_a = rs1_value;
    decode_next.wb_src    = is_move ? core_pkg::SRC_MOVE : core_pkg::SRC_ALU;
    decode_next.wb_reg    = rs1_idx;

    // Second operand
    if (imm_flag) begin
      if (op == core_pkg::OP_MOVU) begin
        decode_next.operand_b = {imm, 16'h0000}; // Upper half placement
      end else begin
        decode_next.operand_b = {16'h0000, imm};
      end
    end else begin
      decode_next.operand_b = rs2_value;
    end

    // Halfword write mask
    if (!is_alu) begin
      decode_next.wb_mask = 2'b00;
    end else if (op == core_pkg::OP_MOVL) begin
      decode_next.wb_mask = 2'b01;
    end else if (op == core_pkg::OP_MOVU) begin
      decode_next.wb_mask = 2'b10;
    end else begin
      decode_next.wb_mask = 2'b11;
    end
  end

  // Decode pipeline register
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      decode_ex <= '0;
    end else if (stall) begin
      decode_ex <= '0; // Bubble writes nothing
    end else begin
      decode_ex <= decode_next;
    end
  end

endmodule

// File: hazard_unit.sv
module hazard_unit (
  input  core_pkg::reg_idx_t   rs1_idx,
  input  core_pkg::reg_idx_t   rs2_idx,
  input  logic                 rs1_used,
  input  logic                 rs2_used,
  input  core_pkg::decode_ex_t decode_ex,
  input  core_pkg::result_t    result,
  output logic                 stall
);

  logic rs1_hit;
  logic rs2_hit;

  // True when a pending writer targets this register
  function automatic logic pending_write(
    input core_pkg::reg_idx_t   idx,
    input core_pkg::decode_ex_t dx,
    input core_pkg::result_t    rs
  );
    logic dx_hit;
    logic rs_hit;
    dx_hit = (dx.wb_mask != 2'b00) && (dx.wb_reg == idx);
    rs_hit = (rs.wb_mask != 2'b00) && (rs.wb_reg == idx);
    return dx_hit || rs_hit;
  endfunction

  assign rs1_hit = rs1_used && pending_write(rs1_idx, decode_ex, result);
  assign rs2_hit = rs2_used && pending_write(rs2_idx, decode_ex, result);

  // Used flags are only set for ALU words
  assign stall = rs1_hit || rs2_hit;

endmodule

// File: instr_execute.sv
module instr_execute (
  input  logic                 clock,
  input  logic                 reset,
  input  core_pkg::decode_ex_t decode_ex,
  output core_pkg::result_t    result
);

  core_pkg::word_t   alu_out;
  core_pkg::word_t   wb_data;
  core_pkg::result_t result_next;

  // ALU
  always_comb begin
    case (decode_ex.alu_op)
      core_pkg::OP_ADD: alu_out = decode_ex.operand_a + decode_ex.operand_b;
      core_pkg::OP_INC: alu_out = decode_ex.operand_a + 32'd1;
      default:          alu_out = '0; // Undefined arithmetic codes
    endcase
  end

  // Moves take the prepared second operand
  assign wb_data = (decode_ex.wb_src == core_pkg::SRC_MOVE) ? decode_ex.operand_b : alu_out;

  always_comb begin
    result_next.wb_reg  = decode_ex.wb_reg;
    result_next.wb_mask = decode_ex.wb_mask;
    result_next.wb_data = wb_data;
  end

  // Execute pipeline register
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      result <= '0;
    end else begin
      result <= result_next;
    end
  end

endmodule

// File: reg_file.sv
module reg_file (
  input  logic               clock,
  input  logic               reset,
  input  core_pkg::reg_idx_t rs1_idx,
  input  core_pkg::reg_idx_t rs2_idx,
  output core_pkg::word_t    rs1_value,
  output core_pkg::word_t    rs2_value,
  input  core_pkg::result_t  result,
  output core_pkg::word_t    r0_value,
  output core_pkg::word_t    r1_value
);

  localparam int LO_MSB = core_pkg::HALF_W - 1;
  localparam int HI_MSB = core_pkg::WORD_W - 1;

  core_pkg::word_t regs [core_pkg::NUM_REGS];

  // Halfword-masked write at the end of the result cycle
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (result.wb_mask[0]) begin
        regs[result.wb_reg][LO_MSB:0] <= result.wb_data[LO_MSB:0];
      end
      if (result.wb_mask[1]) begin
        regs[result.wb_reg][HI_MSB:core_pkg::HALF_W] <= result.wb_data[HI_MSB:core_pkg::HALF_W];
      end
    end
  end

  // No bypass of a same-cycle write
  assign rs1_value = regs[rs1_idx];
  assign rs2_value = regs[rs2_idx];

  // Observation taps
  assign r0_value = regs[0];
  assign r1_value = regs[1];

endmodule

// File: core_top.sv
module core_top (
  input  logic            clock,
  input  logic            reset,
  input  core_pkg::instr_t instr,
  output logic            stall,
  output core_pkg::word_t r0_value,
  output core_pkg::word_t r1_value
);

  core_pkg::reg_idx_t   rs1_idx;
  core_pkg::reg_idx_t   rs2_idx;
  logic                 rs1_used;
  logic                 rs2_used;
  core_pkg::word_t      rs1_value;
  core_pkg::word_t      rs2_value;
  core_pkg::decode_ex_t decode_ex;
  core_pkg::result_t    result;

  instr_decode u_decode (
    .clock     (clock),
    .reset     (reset),
    .instr     (instr),
    .stall     (stall),
    .rs1_idx   (rs1_idx),
    .rs2_idx   (rs2_idx),
    .rs1_used  (rs1_used),
    .rs2_used  (rs2_used),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .decode_ex (decode_ex)
  );

  hazard_unit u_hazard (
    .rs1_idx   (rs1_idx),
    .rs2_idx   (rs2_idx),
    .rs1_used  (rs1_used),
    .rs2_used  (rs2_used),
    .decode_ex (decode_ex),
    .result    (result),
    .stall     (stall)
  );

  instr_execute u_execute (
    .clock     (clock),
    .reset     (reset),
    .decode_ex (decode_ex),
    .result    (result)
  );

  // Result stage writes back here
  reg_file u_reg_file (
    .clock     (clock),
    .reset     (reset),
    .rs1_idx   (rs1_idx),
    .rs2_idx   (rs2_idx),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .result    (result),
    .r0_value  (r0_value),
    .r1_value  (r1_value)
  );

endmodule

// File: core_assert.sv
module core_assert (
  input logic               clock,
  input logic               reset,
  input logic               stall,
  input core_pkg::instr_t   fetch_q,
  input core_pkg::half_en_t dx_mask
);
  timeunit 1ns;
  timeprecision 1ps;

  logic fetch_is_alu;

  assign fetch_is_alu = (fetch_q[core_pkg::TYPE_MSB:core_pkg::TYPE_LSB] == core_pkg::TYPE_ALU);

  // Only ALU words can wait on a writer
  assert property (@(posedge clock) disable iff (reset) !fetch_is_alu |-> !stall)
    else $error("stall high while fetch holds a no-op");

  assert property (@(posedge clock) disable iff (reset) stall |=> (dx_mask == 2'b00))
    else $error("decode stage wrote after a stall instead of a bubble");

  // Fetch holds its word across a stalled edge
  assert property (@(posedge clock) disable iff (reset) stall |=> $stable(fetch_q))
    else $error("fetch register changed across a stalled edge");

endmodule

bind core_top core_assert u_core_assert (
  .clock   (clock),
  .reset   (reset),
  .stall   (stall),
  .fetch_q (u_decode.fetch_q),
  .dx_mask (decode_ex.wb_mask)
);

// File: tb_core.sv
module tb_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_HALF     = 4;
  localparam int RESET_CYCLES = 3;
  localparam int STALL_LIMIT  = 10;
  localparam int DRAIN_NOPS   = 4;

  typedef struct packed {
    core_pkg::instr_t instr;
    logic [3:0]       stalls; // Cycles this word sits stalled in fetch
    logic             checkpoint;
    core_pkg::word_t  exp_r0;
    core_pkg::word_t  exp_r1;
  } row_t;

  logic             clock;
  logic             reset;
  core_pkg::instr_t instr;
  logic             stall;
  core_pkg::word_t  r0_value;
  core_pkg::word_t  r1_value;

  core_pkg::word_t model [core_pkg::NUM_REGS]; // Architectural register state
  row_t            rows [$];
  int              errors;
  int              checks;
  bit              timed_out;
  int              seed;
  string           prev_tag;
  int              prev_expect;

  core_top dut (
    .clock    (clock),
    .reset    (reset),
    .instr    (instr),
    .stall    (stall),
    .r0_value (r0_value),
    .r1_value (r1_value)
  );

  always #CLK_HALF clock = ~clock;

  function automatic core_pkg::instr_t encode(input logic imm_flag, input logic [1:0] kind,
                                              input logic [2:0] op, input core_pkg::reg_idx_t rd,
                                              input core_pkg::reg_idx_t rs2,
                                              input core_pkg::half_t imm);
    core_pkg::instr_t w;
    w = '0;
    w[core_pkg::IMM_BIT] = imm_flag;
    w[core_pkg::TYPE_MSB:core_pkg::TYPE_LSB] = kind;
    w[core_pkg::OP_MSB:core_pkg::OP_LSB] = op;
    w[core_pkg::RS1_MSB:core_pkg::RS1_LSB] = rd;
    w[core_pkg::RS2_MSB:core_pkg::RS2_LSB] = rs2;
    w[core_pkg::IMM_MSB:core_pkg::IMM_LSB] = imm;
    return w;
  endfunction

  // Sequential effect of one word on the model
  function automatic void model_step(input core_pkg::instr_t w);
    logic [1:0]         kind;
    logic [2:0]         op;
    logic               imm_flag;
    core_pkg::reg_idx_t rd;
    core_pkg::reg_idx_t rs2;
    core_pkg::half_t    imm;
    core_pkg::word_t    a;
    core_pkg::word_t    b;
    core_pkg::word_t    data;
    core_pkg::half_en_t mask;
    kind     = w[core_pkg::TYPE_MSB:core_pkg::TYPE_LSB];
    op       = w[core_pkg::OP_MSB:core_pkg::OP_LSB];
    imm_flag = w[core_pkg::IMM_BIT];
    rd       = w[core_pkg::RS1_MSB:core_pkg::RS1_LSB];
    rs2      = w[core_pkg::RS2_MSB:core_pkg::RS2_LSB];
    imm      = w[core_pkg::IMM_MSB:core_pkg::IMM_LSB];
    if (kind != core_pkg::TYPE_ALU) return; // MEM and AUDIO leave state alone
    a    = model[rd];
    b    = imm_flag ? {16'h0000, imm} : model[rs2];
    mask = 2'b11;
    case (op)
      core_pkg::OP_ADD: data = a + b;
      core_pkg::OP_INC: data = a + 32'd1;
      core_pkg::OP_MOV: data = b;
      core_pkg::OP_MOVL: begin
        data = b;
        mask = 2'b01;
      end
      core_pkg::OP_MOVU: begin
        data = imm_flag ? {imm, 16'h0000} : model[rs2];
        mask = 2'b10;
      end
      default: data = '0;
    endcase
    if (mask[0]) model[rd][15:0] = data[15:0];
    if (mask[1]) model[rd][31:16] = data[31:16];
  endfunction

  function automatic void add_row(input core_pkg::instr_t w, input int stalls,
                                  input bit checkpoint);
    row_t r;
    model_step(w);
    r.instr      = w;
    r.stalls     = 4'(stalls);
    r.checkpoint = checkpoint;
    r.exp_r0     = model[0];
    r.exp_r1     = model[1];
    rows.push_back(r);
  endfunction

  function automatic core_pkg::half_t rand_half();
    return core_pkg::half_t'($random(seed));
  endfunction

  function automatic void build_table();
    core_pkg::half_t imm_a;
    core_pkg::half_t imm_b;
    core_pkg::half_t imm_c;
    core_pkg::half_t imm_d;
    core_pkg::half_t imm_e;
    for (int i = 0; i < core_pkg::NUM_REGS; i++) model[i] = '0;
    imm_a = rand_half();
    imm_b = rand_half();
    imm_c = rand_half();
    imm_d = rand_half();
    imm_e = rand_half();
    // Build R0 and R1 one half at a time
    add_row(encode(1'b1, core_pkg::TYPE_ALU, core_pkg::OP_MOVL, 3'd0, 3'd0, 16'h5678), 0, 1'b0);
    add_row(encode(1'b1, core_pkg::TYPE_ALU, core_pkg::OP_MOVU, 3'd1, 3'd0, 16'hABCD), 0, 1'b0);
    add_row(encode(1'b1, core_pkg::TYPE_ALU, core_pkg::OP_MOVU, 3'd0, 3'd0, 16'h1234), 1, 1'b0);
    add_row(encode(1'b1, core_pkg::TYPE_ALU, core_pkg::OP_MOVL, 3'd1, 3'd0, 16'h1111), 0, 1'b1);
    // Arithmetic with back-to-back dependencies
    add_row(encode(1'b1, core_pkg::TYPE_ALU, core_pkg::OP_MOVL, 3'd2, 3'd0, imm_a), 0, 1'b0);
    add_row(encode(1'b1, core_pkg::TYPE_ALU, core_pkg::OP_MOVL, 3'd3, 3'd0, imm_b), 0, 1'b0);
    add_row(encode(1'b0, core_pkg::TYPE_ALU, core_pkg::OP_ADD, 3'd2, 3'd3, 16'h0000), 2, 1'b0);
    add_row(encode(1'b1, core_pkg::TYPE_ALU, core_pkg::OP_ADD, 3'd2, 3'd0, imm_e), 2, 1'b0);
    add_row(encode(1'b0, core_pkg::TYPE_ALU, core_pkg::OP_INC, 3'd4, 3'd0, 16'h0000), 0, 1'b0);
    add_row(encode(1'b0, core_pkg::TYPE_ALU, core_pkg::OP_MOV, 3'd0, 3'd2, 16'h0000), 1, 1'b0);
    add_row(encode(1'b0, core_pkg::TYPE_ALU, core_pkg::OP_ADD, 3'd1, 3'd4, 16'h0000), 0, 1'b1);
    // Independent words with MEM and AUDIO in between
    add_row(encode(1'b1, core_pkg::TYPE_ALU, core_pkg::OP_MOVL, 3'd5, 3'd0, imm_c), 0, 1'b0);
    add_row(encode(1'b1, core_pkg::TYPE_ALU, core_pkg::OP_MOVL, 3'd6, 3'd0, imm_d), 0, 1'b0);
    add_row(encode(1'b1, core_pkg::TYPE_MEM, core_pkg::OP_ADD, 3'd6, 3'd0, 16'hFFFF), 0, 1'b0);
    add_row(encode(1'b0, core_pkg::TYPE_AUDIO, core_pkg::OP_MOV, 3'd0, 3'd6, 16'h0F0F), 0, 1'b0);
    add_row(encode(1'b0, core_pkg::TYPE_ALU, core_pkg::OP_INC, 3'd0, 3'd0, 16'h0000), 0, 1'b0);
    add_row(encode(1'b0, core_pkg::TYPE_ALU, core_pkg::OP_INC, 3'd1, 3'd0, 16'h0000), 0, 1'b0);
    add_row(encode(1'b1, core_pkg::TYPE_ALU, core_pkg::OP_MOVU, 3'd7, 3'd0, 16'hFFFF), 0, 1'b0);
    add_row(encode(1'b1, core_pkg::TYPE_ALU, core_pkg::OP_ADD, 3'd0, 3'd0, 16'h0010), 0, 1'b0);
    add_row(encode(1'b0, core_pkg::TYPE_ALU, core_pkg::OP_MOV, 3'd1, 3'd5, 16'h0000), 0, 1'b0);
    add_row(encode(1'b0, core_pkg::TYPE_ALU, core_pkg::OP_ADD, 3'd0, 3'd6, 16'h0000), 1, 1'b1);
  endfunction

  // Returns just before the edge that takes the word into fetch
  task automatic issue(input core_pkg::instr_t w, output int stalls);
    @(posedge clock);
    instr <= w;
    stalls = 0;
    @(negedge clock);
    while (stall && !timed_out) begin
      stalls++;
      if (stalls >= STALL_LIMIT) begin
        $display("Timeout: stall stayed high for %0d cycles, giving up", stalls);
        errors++;
        timed_out = 1'b1;
      end else begin
        @(negedge clock);
      end
    end
  endtask

  // Stalls seen now belong to the word already in fetch
  task automatic send(input core_pkg::instr_t w, input string tag, input int expect_stalls);
    int got;
    issue(w, got);
    if (!timed_out) begin
      checks++;
      if (got != prev_expect) begin
        $display("** Error: stall cycles for %s: got 0x%0h, expected 0x%0h",
                 prev_tag, got, prev_expect);
        errors++;
      end
    end
    prev_tag    = tag;
    prev_expect = expect_stalls;
  endtask

  task automatic check_regs(input int idx);
    checks++;
    if (r0_value !== rows[idx].exp_r0) begin
      $display("** Error: r0_value after row %0d: got 0x%h, expected 0x%h",
               idx, r0_value, rows[idx].exp_r0);
      errors++;
    end
    if (r1_value !== rows[idx].exp_r1) begin
      $display("** Error: r1_value after row %0d: got 0x%h, expected 0x%h",
               idx, r1_value, rows[idx].exp_r1);
      errors++;
    end
  endtask

  initial begin
    clock       = 1'b0;
    reset       = 1'b1;
    instr       = '0;
    errors      = 0;
    checks      = 0;
    timed_out   = 1'b0;
    seed        = 90;
    prev_tag    = "reset no-op";
    prev_expect = 0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;

    foreach (rows[i]) begin
      if (!timed_out) begin
        send(rows[i].instr, $sformatf("row %0d", i), int'(rows[i].stalls));
        if (rows[i].checkpoint) begin
          // Drain the pipeline before looking at R0 and R1
          for (int n = 0; n < DRAIN_NOPS; n++) begin
            if (!timed_out) send('0, "no-op", 0);
          end
          if (!timed_out) check_regs(i);
        end
      end
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: sim.f
core_pkg.sv
instr_decode.sv
hazard_unit.sv
instr_execute.sv
reg_file.sv
core_top.sv
core_assert.sv
tb_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_core
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
